/* all.f */
src/hdc_pkg.sv
src/hv_permute.sv
src/hv_random_gen.sv
src/hv_bundler.sv
src/hdc_core.sv
src/hdc_accel_top.sv
dv/hdc_accel_tb.sv

/* dv/hdc_accel_tb.sv */
`timescale 1ns/1ps

module hdc_accel_tb;
    import hdc_pkg::*;

    typedef struct packed {
        logic is_last;
        hv_t  vec;
    } expect_t;

    // generator start value
    localparam logic [63:0] GEN_SEED = 64'h0123456789abcdef;

    // clocks from driving get_v to seeing its pulse at a falling edge
    localparam int PULSE_LATENCY = 3;

    logic       clk = 1'b0;
    logic       reset;
    logic       run;
    logic       gen;
    item_addr_t item_a;
    logic       get_v;
    inst_t      get_d;
    logic       store;
    logic       last;
    hv_t        core_result;

    expect_t expected[$];
    int      issued[$];
    string   lines[$];
    int      errors = 0;
    int      cycles = 0;
    int      limit = 0;

    always #5 clk = ~clk;

    hdc_accel_top hdc_accel_top_i (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .gen         (gen),
        .item_a      (item_a),
        .get_v       (get_v),
        .get_d       (get_d),
        .store       (store),
        .last        (last),
        .core_result (core_result)
    );

    function automatic hv_t xorshift(hv_t x);
        hv_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        return y ^ (y << 17);
    endfunction

    // k-th vector handed out by the generator since reset
    function automatic hv_t rnd_item(int k);
        hv_t x;
        x = GEN_SEED;
        for (int i = 0; i < k; i++) begin
            x = xorshift(x);
        end
        return x;
    endfunction

    function automatic hv_t rotl(hv_t v, int r);
        if (r == 0) begin
            return v;
        end
        return (v << r) | (v >> (HV_WIDTH - r));
    endfunction

    // m picks single term, xor of two, majority of three, or zero
    function automatic hv_t expected_vec(int m, int a, int ra, int b, int rb, int c, int rc);
        hv_t x;
        hv_t y;
        hv_t z;
        x = rotl(rnd_item(a), ra);
        y = rotl(rnd_item(b), rb);
        z = rotl(rnd_item(c), rc);
        case (m)
            0: return x;
            1: return x ^ y;
            2: return (x & y) | (x & z) | (y & z);
            default: return '0;
        endcase
    endfunction

    // store or last, after memory ops and xor in execute priority
    function automatic logic makes_pulse(inst_t w);
        if (w[INST_MEM] || w[INST_XOR]) begin
            return 1'b0;
        end
        return w[INST_STORE] || (!w[INST_MOVE] && w[INST_LAST]);
    endfunction

    task automatic check(hv_t got, hv_t exp, string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk);
            gen = 1'b0;
            get_v = 1'b0;
        end
    endtask

    task automatic issue(inst_t word, int n);
        repeat (n) begin
            @(negedge clk);
            gen = 1'b0;
            get_v = 1'b1;
            get_d = word;
            if (makes_pulse(word)) begin
                issued.push_back(cycles);
            end
        end
    endtask

    task automatic gen_item(item_addr_t addr);
        @(negedge clk);
        get_v = 1'b0;
        gen = 1'b1;
        item_a = addr;
    endtask

    // run low for one cycle resets schedule, pipeline and bundler
    task automatic restart();
        idle(1);
        run = 1'b0;
        @(negedge clk);
        run = 1'b1;
    endtask

    always @(negedge clk) begin
        expect_t e;
        int      t;
        if (!reset && (store || last)) begin
            if (expected.size() == 0) begin
                $display("error at %0t: store or last pulse when none was expected", $time);
                errors++;
            end else begin
                e = expected.pop_front();
                check(hv_t'(last), hv_t'(e.is_last), "pulse kind");
                check(core_result, e.vec, "store vector");
            end
            if (issued.size() == 0) begin
                $display("error at %0t: pulse with no store or last instruction issued",
                         $time);
                errors++;
            end else begin
                t = issued.pop_front();
                check(hv_t'(cycles - t), hv_t'(PULSE_LATENCY), "pulse latency");
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int         fd;
        string      line;
        string      name;
        byte        cmd;
        logic [15:0] word;
        int         n;
        int         m;
        int         a;
        int         ra;
        int         b;
        int         rb;
        int         c;
        int         rc;
        int         tests = 0;
        int         failed = 0;
        int         test_errors = 0;
        expect_t    e;
        reset = 1'b1;
        run = 1'b0;
        gen = 1'b0;
        item_a = '0;
        get_v = 1'b0;
        get_d = '0;
        fd = $fopen("dv/hdc_tests.txt", "r");
        if (fd == 0) begin
            $display("error: could not open dv/hdc_tests.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                lines.push_back(line);
            end
        end
        limit = lines.size() * 20 + 100;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (lines[i]) begin
            line = lines[i];
            cmd = line.getc(0);
            case (cmd)
                "T": begin
                    void'($sscanf(line, "T %s", name));
                    test_errors = errors;
                end
                "R": restart();
                "G": begin
                    void'($sscanf(line, "G %h", a));
                    gen_item(item_addr_t'(a));
                end
                "I": begin
                    void'($sscanf(line, "I %h %d", word, n));
                    issue(word, n);
                end
                "N": begin
                    void'($sscanf(line, "N %d", n));
                    idle(n);
                end
                "S": begin
                    void'($sscanf(line, "S %d %d %d %d %d %d %d", m, a, ra, b, rb, c, rc));
                    e.is_last = 1'b0;
                    e.vec = expected_vec(m, a, ra, b, rb, c, rc);
                    expected.push_back(e);
                end
                "L": begin
                    e.is_last = 1'b1;
                    e.vec = '0;
                    expected.push_back(e);
                end
                "E": begin
                    // pulses arrive three clocks after issue
                    idle(4);
                    if (expected.size() != 0) begin
                        $display("error: test %s ended with %0d expected pulses missing",
                                 name, expected.size());
                        errors++;
                        expected.delete();
                    end
                    if (issued.size() != 0) begin
                        $display("error: test %s ended with %0d issued pulses not seen",
                                 name, issued.size());
                        errors++;
                        issued.delete();
                    end
                    tests++;
                    if (errors == test_errors) begin
                        $display("test %s: ok", name);
                    end else begin
                        $display("test %s: %0d errors", name, errors - test_errors);
                        failed++;
                    end
                end
                default: ;
            endcase
        end
        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0 && tests > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* dv/hdc_tests.txt */
# T name | R restart run | G addr | I word count | N cycles | L last | E end
# S m a ra b rb c rc: m 0 one term, 1 xor, 2 majority; terms are generator item a rotated by ra
T fill_bind_threads
R
G 010
G 011
G 012
S 0 1 0 0 0 0 0
S 0 2 0 0 0 0 0
S 1 0 0 1 0 0 0
I A010 1
I A011 1
I A012 1
I 0000 7
I 0800 1
I 1000 2
I 0000 7
I A011 1
I 0000 9
I 2000 1
I 0000 9
I 1000 1
E
T perm_wb_bundle
R
S 0 1 1 0 0 0 0
S 0 2 63 0 0 0 0
S 0 0 1 0 0 0 0
S 2 1 1 2 63 0 1
I A010 1
I A011 1
I A012 1
I 0000 7
I D041 1
I 5001 1
I 503F 1
I 0000 7
I A041 1
I 0000 9
I 1000 1
I 0000 9
I 0200 1
I 0000 9
I 1000 1
E
T last_run
R
L
S 2 1 1 2 63 0 1
I 0400 1
N 3
R
I 1000 1
E

/* run.sh */
#!/bin/sh
# build and run the hdc accelerator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module hdc_accel_tb -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vhdc_accel_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
exit 1

/* src/hdc_accel_top.sv */
`timescale 1ns/1ps

module hdc_accel_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  logic                gen,
    input  hdc_pkg::item_addr_t item_a,
    input  logic                get_v,
    input  hdc_pkg::inst_t      get_d,
    output logic                store,
    output logic                last,
    output hdc_pkg::hv_t        core_result
);
    import hdc_pkg::*;

    hv_t        rand_vec;
    hv_t        sign_vec;
    store_out_t core_out;

    hv_random_gen hv_random_gen_i (
        .clk      (clk),
        .reset    (reset),
        .advance  (gen),
        .rand_vec (rand_vec)
    );

    hdc_core hdc_core_i (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .gen      (gen),
        .item_a   (item_a),
        .rand_vec (rand_vec),
        .get_v    (get_v),
        .get_d    (get_d),
        .sign_vec (sign_vec),
        .out      (core_out)
    );

    // every stored vector is bundled
    hv_bundler hv_bundler_i (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .store    (core_out.store),
        .data     (core_out.result),
        .sign_vec (sign_vec)
    );

    assign store       = core_out.store;
    assign last        = core_out.last;
    assign core_result = core_out.result;

endmodule

/* src/hdc_core.sv */
`timescale 1ns/1ps

module hdc_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  logic                gen,
    input  hdc_pkg::item_addr_t item_a,
    input  hdc_pkg::hv_t        rand_vec,
    input  logic                get_v,
    input  hdc_pkg::inst_t      get_d,
    input  hdc_pkg::hv_t        sign_vec,
    output hdc_pkg::store_out_t out
);
    import hdc_pkg::*;

    // storage
    hv_t item_mem  [ITEM_DEPTH];
    hv_t reg1_file [NUM_THREADS];
    hv_t reg2_file [NUM_THREADS];

    // next thread to receive an instruction
    thread_id_t thread_cnt;

    // decode/read stage
    logic       s1_valid;
    inst_t      s1_inst;
    thread_id_t s1_thread;
    hv_t        s1_mem;
    hv_t        s1_reg1;
    hv_t        s1_reg2;

    // permute stage, feeds execute
    logic       s2_valid;
    inst_t      s2_inst;
    thread_id_t s2_thread;
    hv_t        s2_mem;
    hv_t        s2_reg1;
    hv_t        s2_reg2;

    hv_t perm_result;
    hv_t src;

    logic is_mem;
    logic is_alu;
    logic do_load;
    logic do_wb;
    logic do_xor;
    logic do_store;
    logic do_move;
    logic do_last;
    logic do_sign;

    // scheduler and pipeline valids
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            thread_cnt <= '0;
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
        end else begin
            s1_valid <= get_v;
            s2_valid <= s1_valid;
            if (get_v) begin
                if (thread_cnt == thread_id_t'(NUM_THREADS - 1)) begin
                    thread_cnt <= '0;
                end else begin
                    thread_cnt <= thread_cnt + 1'b1;
                end
            end
        end
    end

    // item memory, one write port and a registered read
    always_ff @(posedge clk) begin
        // write-back takes the port over a random fill
        if (do_wb) begin
            item_mem[s2_inst[INST_ADDR_MSB:0]] <= src;
        end else if (gen) begin
            item_mem[item_a] <= rand_vec;
        end
        if (get_v) begin
            s1_mem <= item_mem[get_d[INST_ADDR_MSB:0]];
        end
    end

    // stage payloads
    always_ff @(posedge clk) begin
        if (get_v) begin
            s1_inst   <= get_d;
            s1_thread <= thread_cnt;
            s1_reg1   <= reg1_file[thread_cnt];
            s1_reg2   <= reg2_file[thread_cnt];
        end
        if (s1_valid) begin
            s2_inst   <= s1_inst;
            s2_thread <= s1_thread;
            s2_mem    <= s1_mem;
            s2_reg1   <= s1_reg1;
            s2_reg2   <= s1_reg2;
        end
    end

    hv_permute hv_permute_i (
        .clk    (clk),
        .en     (s1_valid),
        .data   (s1_reg2),
        .amount (s1_inst[INST_ROT_MSB:0]),
        .result (perm_result)
    );

    // source operand
    assign src = s2_inst[INST_PERM] ? perm_result : s2_reg2;

    // execute decode, memory ops take priority
    assign is_mem  = s2_valid && s2_inst[INST_MEM];
    assign do_load = is_mem && s2_inst[INST_XOR];
    assign do_wb   = is_mem && !s2_inst[INST_XOR] && s2_inst[INST_STORE];

    assign is_alu   = s2_valid && !s2_inst[INST_MEM];
    assign do_xor   = is_alu && s2_inst[INST_XOR];
    assign do_store = is_alu && !s2_inst[INST_XOR] && s2_inst[INST_STORE];
    assign do_move  = is_alu && !s2_inst[INST_XOR] && !s2_inst[INST_STORE]
                      && s2_inst[INST_MOVE];
    assign do_last  = is_alu && !s2_inst[INST_XOR] && !s2_inst[INST_STORE]
                      && !s2_inst[INST_MOVE] && s2_inst[INST_LAST];
    assign do_sign  = is_alu && !s2_inst[INST_XOR] && !s2_inst[INST_STORE]
                      && !s2_inst[INST_MOVE] && !s2_inst[INST_LAST] && s2_inst[INST_SIGN];

    // thread register write-back
    always_ff @(posedge clk) begin
        if (do_load) begin
            reg2_file[s2_thread] <= s2_mem;
        end else if (do_xor) begin
            reg2_file[s2_thread] <= s2_reg1 ^ src;
        end else if (do_sign) begin
            reg2_file[s2_thread] <= sign_vec;
        end
        if (do_move) begin
            reg1_file[s2_thread] <= src;
        end
    end

    // store and last are single-cycle pulses
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            out <= '0;
        end else begin
            out.store  <= do_store;
            out.last   <= do_last;
            out.result <= do_store ? src : '0;
        end
    end

    // one execute result per cycle
    a_store_last_excl: assert property (
        @(posedge clk) disable iff (reset) !(out.store && out.last)
    );

    // host only issues while running
    a_get_v_needs_run: assert property (
        @(posedge clk) disable iff (reset) get_v |-> run
    );

endmodule

/* src/hdc_pkg.sv */
package hdc_pkg;

    // hypervector geometry
    localparam int HV_WIDTH = 64;

    typedef logic [HV_WIDTH-1:0] hv_t;

    // item memory
    localparam int ITEM_DEPTH  = 512;
    localparam int ITEM_ADDR_W = $clog2(ITEM_DEPTH);

    typedef logic [ITEM_ADDR_W-1:0] item_addr_t;

    // hardware threads, issued round-robin
    localparam int NUM_THREADS = 10;

    typedef logic [$clog2(NUM_THREADS)-1:0] thread_id_t;

    // instruction word
    localparam int INST_W = 16;

    typedef logic [INST_W-1:0] inst_t;

    // instruction bit positions
    localparam int INST_MEM      = 15;
    localparam int INST_PERM     = 14;
    // with INST_MEM this selects a load
    localparam int INST_XOR      = 13;
    // with INST_MEM this selects a write-back
    localparam int INST_STORE    = 12;
    localparam int INST_MOVE     = 11;
    localparam int INST_LAST     = 10;
    localparam int INST_SIGN     = 9;
    localparam int INST_ADDR_MSB = 8;
    localparam int INST_ROT_MSB  = 5;

    typedef logic [INST_ROT_MSB:0] rot_amt_t;

    // bundler counters, signed and saturating
    localparam int BUNDLE_CNT_W = 6;

    typedef logic signed [BUNDLE_CNT_W-1:0] bundle_cnt_t;

    // xorshift seed, must be nonzero
    localparam logic [63:0] RAND_SEED = 64'h0123456789abcdef;

    // core result toward top level and bundler
    typedef struct packed {
        logic store;
        logic last;
        hv_t  result;
    } store_out_t;

endpackage

/* src/hv_bundler.sv */
`timescale 1ns/1ps

module hv_bundler (
    input  logic         clk,
    input  logic         reset,
    input  logic         run,
    input  logic         store,
    input  hdc_pkg::hv_t data,
    output hdc_pkg::hv_t sign_vec
);
    import hdc_pkg::*;

    localparam bundle_cnt_t CNT_MAX = bundle_cnt_t'((1 << (BUNDLE_CNT_W - 1)) - 1);
    localparam bundle_cnt_t CNT_MIN = bundle_cnt_t'(-(1 << (BUNDLE_CNT_W - 1)));

    bundle_cnt_t cnt      [HV_WIDTH];
    bundle_cnt_t cnt_next [HV_WIDTH];

    // plus one per set bit, minus one per clear bit
    always_comb begin
        for (int i = 0; i < HV_WIDTH; i++) begin
            cnt_next[i] = cnt[i];
            if (store) begin
                if (data[i] && cnt[i] != CNT_MAX) begin
                    cnt_next[i] = cnt[i] + bundle_cnt_t'(1);
                end else if (!data[i] && cnt[i] != CNT_MIN) begin
                    cnt_next[i] = cnt[i] - bundle_cnt_t'(1);
                end
            end
        end
    end

    // sign taken from the updated counts, so it tracks the store directly
    always_ff @(posedge clk) begin
        for (int i = 0; i < HV_WIDTH; i++) begin
            if (reset || !run) begin
                cnt[i]      <= '0;
                sign_vec[i] <= 1'b0;
            end else begin
                cnt[i]      <= cnt_next[i];
                sign_vec[i] <= cnt_next[i] > 0;
            end
        end
    end

endmodule

/* src/hv_permute.sv */
`timescale 1ns/1ps

module hv_permute (
    input  logic              clk,
    input  logic              en,
    input  hdc_pkg::hv_t      data,
    input  hdc_pkg::rot_amt_t amount,
    output hdc_pkg::hv_t      result
);
    import hdc_pkg::*;

    // two copies side by side, so a left shift wraps the MSBs around
    logic [2*HV_WIDTH-1:0] doubled;

    always_comb begin
        doubled = {data, data} << amount;
    end

    // rotated value sits in the upper half
    always_ff @(posedge clk) begin
        if (en) begin
            result <= doubled[2*HV_WIDTH-1 -: HV_WIDTH];
        end
    end

endmodule

/* src/hv_random_gen.sv */
`timescale 1ns/1ps

module hv_random_gen (
    input  logic         clk,
    input  logic         reset,
    input  logic         advance,
    output hdc_pkg::hv_t rand_vec
);
    import hdc_pkg::*;

    hv_t state;
    hv_t step_a;
    hv_t step_b;
    hv_t state_next;

    // xorshift64 with shifts 13, 7, 17
    always_comb begin
        step_a     = state ^ (state << 13);
        step_b     = step_a ^ (step_a >> 7);
        state_next = step_b ^ (step_b << 17);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hv_t'(RAND_SEED);
        end else if (advance) begin
            state <= state_next;
        end
    end

    assign rand_vec = state;

    // zero is a fixed point of xorshift
    a_state_nonzero: assert property (@(posedge clk) disable iff (reset) state != '0);

endmodule
